// ==== source/trdb_defs.svh ====
`ifndef TRDB_DEFS_SVH
`define TRDB_DEFS_SVH

// number of conditional branches one branch map can hold before it must be closed
`define TRDB_MAP_BITS 31

// the branch count must be able to reach the full map size
`define TRDB_CNT_BITS 5

// width of an indirect jump target as carried in an address packet
`define TRDB_ADDR_BITS 32

// every trace packet has the same width regardless of its format
`define TRDB_PKT_BITS 72

// the serializer sends the packet out in units of this width
`define TRDB_BYTE_BITS 8
`define TRDB_PKT_BYTES 9

// number of complete packets the FIFO can hold between emitter and serializer
`define TRDB_FIFO_DEPTH 4

`endif

// ==== source/trdb_instr_pkg.sv ====
`include "trdb_defs.svh"

// describes what the core reports about a retired instruction
package trdb_instr_pkg;

    // one retirement report per cycle at most
    // is_branch and is_jump are mutually exclusive, and an instruction with
    // neither set is a plain instruction that leaves the trace state untouched
    typedef struct packed {
        // an instruction retired in this cycle
        logic                       valid;
        // the instruction is a conditional branch
        logic                       is_branch;
        // direction of the conditional branch, ignored for anything else
        logic                       taken;
        // the instruction is an indirect jump whose target is not predictable
        logic                       is_jump;
        // destination of the indirect jump, only meaningful with is_jump
        logic [`TRDB_ADDR_BITS-1:0] target;
    } retire_t;

endpackage

// ==== source/trdb_packet_pkg.sv ====
`include "trdb_defs.svh"

// describes the layout of the trace packets on their way to the serializer
package trdb_packet_pkg;

    // the format always sits in the two least significant bits of a packet
    typedef enum logic [1:0] {
        FMT_BRANCH = 2'd1,
        FMT_ADDR   = 2'd2
    } pkt_fmt_e;

    // a full branch map without an address
    // the upper bits are padding so that both views share one width
    typedef struct packed {
        logic [`TRDB_PKT_BITS-`TRDB_MAP_BITS-`TRDB_CNT_BITS-3:0] pad;
        logic [`TRDB_MAP_BITS-1:0]                               map;
        logic [`TRDB_CNT_BITS-1:0]                               count;
        pkt_fmt_e                                                format;
    } branch_pkt_t;

    // a possibly partial branch map followed by the indirect jump target
    // map and count share their bit positions with the branch view
    typedef struct packed {
        logic [`TRDB_PKT_BITS-`TRDB_ADDR_BITS-`TRDB_MAP_BITS-`TRDB_CNT_BITS-3:0] pad;
        logic [`TRDB_ADDR_BITS-1:0]                                             target;
        logic [`TRDB_MAP_BITS-1:0]                                              map;
        logic [`TRDB_CNT_BITS-1:0]                                              count;
        pkt_fmt_e                                                               format;
    } addr_pkt_t;

    // one packet word, read through the view that its format field selects
    // the FIFO and serializer treat it as a plain vector of bits
    typedef union packed {
        branch_pkt_t branch;
        addr_pkt_t   addr;
    } trace_pkt_u;

endpackage

// ==== source/trdb_branch_map.sv ====
`timescale 1ns/1ns

`include "trdb_defs.svh"

module trdb_branch_map (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // a conditional branch retired in this cycle
    input  logic                      valid_i,
    input  logic                      branch_taken_i,
    // start a new map, combined with a branch of the same cycle
    input  logic                      flush_i,

    output logic [`TRDB_MAP_BITS-1:0] map_o,
    output logic [`TRDB_CNT_BITS-1:0] branches_o,
    output logic                      is_full_o,
    output logic                      is_empty_o
);

    logic [`TRDB_MAP_BITS-1:0] map_d;
    logic [`TRDB_MAP_BITS-1:0] map_q;
    logic [`TRDB_CNT_BITS-1:0] branch_cnt_d;
    logic [`TRDB_CNT_BITS-1:0] branch_cnt_q;

    // the count doubles as the bit position of the next branch
    always_comb begin
        map_d        = map_q;
        branch_cnt_d = branch_cnt_q;

        // a flush throws the old map away before anything else happens
        if (flush_i) begin
            map_d        = '0;
            branch_cnt_d = '0;
        end

        if (valid_i) begin
            if (flush_i) begin
                // the branch of the flush cycle opens the new map at bit 0
                map_d[0]     = branch_taken_i;
                branch_cnt_d = `TRDB_CNT_BITS'(1);
            end else begin
                map_d[branch_cnt_q] = branch_taken_i;
                branch_cnt_d        = branch_cnt_q + `TRDB_CNT_BITS'(1);
            end
        end
    end

    // outputs come straight from the next state
    // this lets the emitter close a packet in the cycle of the last branch
    assign map_o      = map_d;
    assign branches_o = branch_cnt_d;
    assign is_full_o  = (branch_cnt_d == `TRDB_CNT_BITS'(`TRDB_MAP_BITS));
    assign is_empty_o = (branch_cnt_d == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_q        <= '0;
            branch_cnt_q <= '0;
        end else begin
            map_q        <= map_d;
            branch_cnt_q <= branch_cnt_d;
        end
    end

endmodule

// ==== source/trdb_packet_emitter.sv ====
`timescale 1ns/1ns

`include "trdb_defs.svh"

module trdb_packet_emitter
    import trdb_instr_pkg::*;
    import trdb_packet_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    // retirement report of the current cycle
    input  retire_t    retire_i,

    // packet and its one-cycle write strobe towards the FIFO
    output trace_pkt_u pkt_o,
    output logic       pkt_write_o
);

    logic                      branch_valid;
    logic                      jump_valid;
    logic                      close_branch;
    logic                      flush_q;
    logic [`TRDB_MAP_BITS-1:0] map;
    logic [`TRDB_CNT_BITS-1:0] branches;
    logic                      map_full;

    // plain instructions never reach the map
    assign branch_valid = retire_i.valid & retire_i.is_branch;
    assign jump_valid   = retire_i.valid & retire_i.is_jump;

    // the map sees no input on a jump cycle
    // its outputs then hold the state the jump packet has to report
    trdb_branch_map i_trdb_branch_map (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .valid_i        (branch_valid),
        .branch_taken_i (retire_i.taken),
        .flush_i        (flush_q),
        .map_o          (map),
        .branches_o     (branches),
        .is_full_o      (map_full),
        .is_empty_o     ()
    );

    // the branch that fills the map closes it in the same cycle
    assign close_branch = branch_valid & map_full;

    // every jump writes a packet, even with an empty map
    assign pkt_write_o = close_branch | jump_valid;

    // fill in the view that matches the packet being closed
    // unused upper bits of the chosen view stay zero
    always_comb begin
        pkt_o = '0;
        if (jump_valid) begin
            pkt_o.addr.format = FMT_ADDR;
            pkt_o.addr.target = retire_i.target;
            pkt_o.addr.map    = map;
            pkt_o.addr.count  = branches;
        end else begin
            pkt_o.branch.format = FMT_BRANCH;
            pkt_o.branch.map    = map;
            pkt_o.branch.count  = branches;
        end
    end

    // a written packet owns the current map contents
    // so the map restarts in the following cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= pkt_write_o;
        end
    end

endmodule

// ==== source/trdb_packet_fifo.sv ====
`timescale 1ns/1ns

`include "trdb_defs.svh"

module trdb_packet_fifo
    import trdb_packet_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    // one-cycle strobes from the emitter and the serializer
    input  logic       write_i,
    input  logic       pop_i,
    input  trace_pkt_u pkt_i,

    // oldest packet, valid while not_empty_o is high
    output trace_pkt_u head_o,
    output logic       not_empty_o,
    // set by the first dropped packet and held until reset
    output logic       overflow_o
);

    localparam int unsigned ptr_bits = $clog2(`TRDB_FIFO_DEPTH);
    localparam int unsigned cnt_bits = $clog2(`TRDB_FIFO_DEPTH + 1);

    trace_pkt_u          mem [`TRDB_FIFO_DEPTH];
    logic [ptr_bits-1:0] wr_ptr_q;
    logic [ptr_bits-1:0] rd_ptr_q;
    logic [cnt_bits-1:0] count_q;
    logic                full;
    logic                do_write;
    logic                do_pop;
    logic                overflow_q;

    // a write into a full FIFO is lost even if a pop happens in the same cycle
    assign full     = (count_q == cnt_bits'(`TRDB_FIFO_DEPTH));
    assign do_write = write_i & ~full;
    assign do_pop   = pop_i & not_empty_o;

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem[wr_ptr_q] <= pkt_i;
        end
    end

    // pointers wrap explicitly so any depth works
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= (wr_ptr_q == ptr_bits'(`TRDB_FIFO_DEPTH - 1)) ? '0 :
                            wr_ptr_q + ptr_bits'(1);
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == ptr_bits'(`TRDB_FIFO_DEPTH - 1)) ? '0 :
                            rd_ptr_q + ptr_bits'(1);
            end
            // a simultaneous write and pop leave the occupancy unchanged
            count_q <= count_q + cnt_bits'(do_write) - cnt_bits'(do_pop);
            if (write_i && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    assign head_o      = mem[rd_ptr_q];
    assign not_empty_o = (count_q != '0);
    assign overflow_o  = overflow_q;

endmodule

// ==== source/trdb_packet_serializer.sv ====
`timescale 1ns/1ns

`include "trdb_defs.svh"

module trdb_packet_serializer
    import trdb_packet_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_ni,

    // FIFO head and its occupancy level
    input  logic                       not_empty_i,
    input  trace_pkt_u                 head_i,
    output logic                       pop_o,

    // one byte per cycle, least significant byte of the packet first
    output logic [`TRDB_BYTE_BITS-1:0] byte_o,
    output logic                       byte_valid_o
);

    localparam int unsigned idx_bits = $clog2(`TRDB_PKT_BYTES);

    logic [`TRDB_PKT_BITS-1:0] shift_q;
    logic [idx_bits-1:0]       idx_q;
    logic                      busy_q;
    logic                      last_byte;

    // the byte on the output right now is the final one of its packet
    assign last_byte = busy_q & (idx_q == idx_bits'(`TRDB_PKT_BYTES - 1));

    // take a new packet when idle or while the last byte goes out
    // so that back-to-back packets leave without a gap
    assign pop_o = not_empty_i & (~busy_q | last_byte);

    // the shift register carries payload only
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            shift_q <= head_i;
        end else if (busy_q) begin
            shift_q <= shift_q >> `TRDB_BYTE_BITS;
        end
    end

    // busy and the byte index follow the nine byte slots of each packet
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else begin
            if (pop_o) begin
                busy_q <= 1'b1;
                idx_q  <= '0;
            end else if (last_byte) begin
                busy_q <= 1'b0;
                idx_q  <= '0;
            end else if (busy_q) begin
                idx_q <= idx_q + idx_bits'(1);
            end
        end
    end

    // the low byte of the shift register is always the next one to send
    assign byte_o       = shift_q[`TRDB_BYTE_BITS-1:0];
    assign byte_valid_o = busy_q;

endmodule

// ==== source/trdb_trace_top.sv ====
`timescale 1ns/1ns

`include "trdb_defs.svh"

module trdb_trace_top
    import trdb_instr_pkg::*;
    import trdb_packet_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_ni,

    // retirement report from the core, sampled every cycle
    input  retire_t                    retire_i,

    // serialized trace stream and the sticky drop indication
    output logic [`TRDB_BYTE_BITS-1:0] byte_o,
    output logic                       byte_valid_o,
    output logic                       overflow_o
);

    trace_pkt_u pkt;
    logic       pkt_write;
    trace_pkt_u head;
    logic       not_empty;
    logic       pop;

    // turns retirements into packets
    trdb_packet_emitter i_trdb_packet_emitter (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .retire_i    (retire_i),
        .pkt_o       (pkt),
        .pkt_write_o (pkt_write)
    );

    // absorbs bursts of packets while the serializer is busy
    trdb_packet_fifo i_trdb_packet_fifo (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .write_i     (pkt_write),
        .pop_i       (pop),
        .pkt_i       (pkt),
        .head_o      (head),
        .not_empty_o (not_empty),
        .overflow_o  (overflow_o)
    );

    // sends each packet out as nine strobed bytes
    trdb_packet_serializer i_trdb_packet_serializer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .not_empty_i  (not_empty),
        .head_i       (head),
        .pop_o        (pop),
        .byte_o       (byte_o),
        .byte_valid_o (byte_valid_o)
    );

endmodule

// ==== testbench/trdb_trace_properties.sv ====
`timescale 1ns/1ns

`include "trdb_defs.svh"

module trdb_trace_properties
    import trdb_packet_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       byte_valid_i,
    input  logic       overflow_i,
    input  logic       pkt_write_i,
    input  trace_pkt_u pkt_i,
    input  logic       flush_pending_i,
    input  logic       pop_i
);

    // number of property failures seen so far
    int unsigned failed_checks = 0;

    // packets held by the FIFO, rebuilt from the strobes on both of its sides
    // a write into a full FIFO is lost even if a pop comes in the same cycle
    int unsigned held;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            held <= 0;
        end else begin
            held <= held + ((pkt_write_i && held < `TRDB_FIFO_DEPTH) ? 1 : 0) -
                    ((pop_i && held != 0) ? 1 : 0);
        end
    end

    // no byte may leave the serializer while reset is held
    reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !byte_valid_i)
        else begin
            failed_checks++;
            $error("byte strobe seen during reset");
        end

    // the drop indication is sticky until the next reset
    overflow_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
        overflow_i |=> overflow_i)
        else begin
            failed_checks++;
            $error("overflow flag fell without reset");
        end

    // with a flush pending no map can be closed, only a jump on an empty map may write
    no_write_on_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (pkt_write_i && flush_pending_i) |->
        (pkt_i.addr.format == FMT_ADDR && pkt_i.addr.count == '0))
        else begin
            failed_checks++;
            $error("packet with stale map written while a flush was pending");
        end

    // the serializer only takes a packet that is really there
    no_empty_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> held != 0)
        else begin
            failed_checks++;
            $error("pop of an empty FIFO");
        end

endmodule

bind trdb_trace_top trdb_trace_properties i_trdb_trace_properties (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .byte_valid_i    (byte_valid_o),
    .overflow_i      (overflow_o),
    .pkt_write_i     (pkt_write),
    .pkt_i           (pkt),
    .flush_pending_i (i_trdb_packet_emitter.flush_q),
    .pop_i           (pop)
);

// ==== testbench/trdb_trace_tb.sv ====
`timescale 1ns/1ns

`include "trdb_defs.svh"

module trdb_trace_tb
    import trdb_instr_pkg::*;
();

    localparam int clk_period      = 8;
    localparam int reset_cycles    = 16;
    localparam int quiet_cycles    = 8;
    // 31 branches with up to two plain gaps each, two jump sequences and a jump burst
    localparam int directed_cycles = 31 * 3 + 11 + 8;
    localparam int random_len      = 200;
    localparam int tail_cycles     = 16;
    // every retirement of the random part could close a packet
    localparam int max_packets     = 12 + random_len;
    localparam int timeout_ns      = clk_period * (reset_cycles + quiet_cycles +
        directed_cycles + random_len + 2 * tail_cycles + 9 * max_packets + 500);

    logic                       clk_i;
    logic                       rst_ni;
    retire_t                    retire_i;
    logic [`TRDB_BYTE_BITS-1:0] byte_o;
    logic                       byte_valid_o;
    logic                       overflow_o;

    // reference model of the map, the FIFO occupancy and the serializer slots
    logic [`TRDB_MAP_BITS-1:0]  ref_map;
    logic [`TRDB_CNT_BITS-1:0]  ref_cnt;
    int                         ref_fifo_cnt;
    logic                       ref_busy;
    int                         ref_idx;
    logic                       ref_overflow;
    logic [`TRDB_PKT_BITS-1:0]  exp_q [$];

    logic [`TRDB_PKT_BITS-1:0]  got;
    int                         got_bytes;
    int                         error_count;
    int                         packet_count;
    int                         prop_fails;
    integer                     seed;
    integer                     rnd;
    int                         gap;

    trdb_trace_top i_trdb_trace_top (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .retire_i     (retire_i),
        .byte_o       (byte_o),
        .byte_valid_o (byte_valid_o),
        .overflow_o   (overflow_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(clk_period / 2) clk_i = ~clk_i;
    end

    function automatic retire_t plain_op();
        retire_t r;
        r = '0;
        r.valid = 1'b1;
        return r;
    endfunction

    function automatic retire_t branch_op(input logic taken);
        retire_t r;
        r = plain_op();
        r.is_branch = 1'b1;
        r.taken = taken;
        return r;
    endfunction

    function automatic retire_t jump_op(input logic [`TRDB_ADDR_BITS-1:0] target);
        retire_t r;
        r = plain_op();
        r.is_jump = 1'b1;
        r.target = target;
        return r;
    endfunction

    // applies the packet rules for one cycle, the update matches the next rising edge
    task automatic model_step(input retire_t r);
        logic [`TRDB_PKT_BITS-1:0] pkt;
        logic                      write;
        logic                      pop;
        write = 1'b0;
        pkt = '0;
        if (r.valid && r.is_branch) begin
            ref_map[ref_cnt] = r.taken;
            ref_cnt = ref_cnt + 5'd1;
            if (ref_cnt == 5'd31) begin
                pkt = {34'b0, ref_map, ref_cnt, 2'd1};
                write = 1'b1;
            end
        end else if (r.valid && r.is_jump) begin
            // a jump adds no bit, so the packet carries the map as it stands
            pkt = {2'b0, r.target, ref_map, ref_cnt, 2'd2};
            write = 1'b1;
        end
        if (write) begin
            ref_map = '0;
            ref_cnt = '0;
        end
        pop = (ref_fifo_cnt != 0) && (!ref_busy || ref_idx == `TRDB_PKT_BYTES - 1);
        // the full check uses the occupancy before a pop of the same cycle
        if (write && ref_fifo_cnt == `TRDB_FIFO_DEPTH) begin
            ref_overflow = 1'b1;
        end else if (write) begin
            exp_q.push_back(pkt);
            ref_fifo_cnt++;
        end
        if (pop) begin
            ref_fifo_cnt--;
            ref_busy = 1'b1;
            ref_idx = 0;
        end else if (ref_busy && ref_idx == `TRDB_PKT_BYTES - 1) begin
            ref_busy = 1'b0;
            ref_idx = 0;
        end else if (ref_busy) begin
            ref_idx++;
        end
    endtask

    task automatic compare_packet();
        logic [`TRDB_PKT_BITS-1:0] exp;
        packet_count++;
        assert (exp_q.size() != 0) else begin
            error_count++;
            $display("[ERROR] %0t: packet %h arrived with none expected", $time, got);
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            assert (got === exp) else begin
                error_count++;
                $display("[ERROR] %0t: packet %h, expected %h", $time, got, exp);
            end
        end
    endtask

    // outputs are registered, so mid-cycle they hold the state of the last rising edge
    task automatic run_cycle(input retire_t r);
        @(negedge clk_i);
        assert (byte_valid_o === ref_busy) else begin
            error_count++;
            $display("[ERROR] %0t: byte_valid_o %b, expected %b", $time, byte_valid_o,
                     ref_busy);
        end
        assert (overflow_o === ref_overflow) else begin
            error_count++;
            $display("[ERROR] %0t: overflow_o %b, expected %b", $time, overflow_o,
                     ref_overflow);
        end
        if (byte_valid_o) begin
            // bytes arrive low first, so each one shifts in from the top
            got = {byte_o, got[`TRDB_PKT_BITS-1:`TRDB_BYTE_BITS]};
            got_bytes++;
            if (got_bytes == `TRDB_PKT_BYTES) begin
                compare_packet();
                got_bytes = 0;
            end
        end
        retire_i = r;
        model_step(r);
    endtask

    task automatic drain_packets();
        while (exp_q.size() != 0) begin
            run_cycle('0);
        end
    endtask

    initial begin
        seed = 99311;
        retire_i = '0;
        rst_ni = 1'b0;
        ref_map = '0;
        ref_cnt = '0;
        ref_fifo_cnt = 0;
        ref_busy = 1'b0;
        ref_idx = 0;
        ref_overflow = 1'b0;
        got = '0;
        got_bytes = 0;
        error_count = 0;
        packet_count = 0;
        repeat (reset_cycles) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        // nothing may come out before the first retirement
        repeat (quiet_cycles) run_cycle('0);

        // a full map of 31 branches with plain instructions in between
        for (int i = 0; i < 31; i++) begin
            rnd = $random(seed);
            run_cycle(branch_op(rnd[0]));
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) run_cycle(plain_op());
        end
        drain_packets();

        // partial maps closed by jumps, then a jump on an empty map
        repeat (5) begin
            rnd = $random(seed);
            run_cycle(branch_op(rnd[0]));
        end
        run_cycle(jump_op($random(seed)));
        repeat (3) begin
            rnd = $random(seed);
            run_cycle(branch_op(rnd[0]));
        end
        run_cycle(jump_op($random(seed)));
        run_cycle(jump_op($random(seed)));
        drain_packets();

        // back-to-back jumps outrun the serializer and overflow the FIFO
        repeat (8) run_cycle(jump_op($random(seed)));
        assert (ref_overflow) else begin
            error_count++;
            $display("the jump burst did not fill the FIFO, overflow was never reached");
        end
        drain_packets();

        // random mix of branches, jumps, plain instructions and idle cycles
        for (int i = 0; i < random_len; i++) begin
            rnd = $random(seed);
            gap = $unsigned(rnd) % 8;
            if (gap < 4) begin
                run_cycle(branch_op(rnd[8]));
            end else if (gap == 4) begin
                run_cycle(jump_op($random(seed)));
            end else if (gap == 5) begin
                run_cycle('0);
            end else begin
                run_cycle(plain_op());
            end
        end
        drain_packets();
        // stray bytes after the last packet would show up here
        repeat (tail_cycles) run_cycle('0);

        prop_fails = i_trdb_trace_top.i_trdb_trace_properties.failed_checks;
        $display("errors: %0d value, %0d property; packets checked: %0d",
                 error_count, prop_fails, packet_count);
        if (error_count == 0 && prop_fails == 0 && packet_count > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the run did not finish within %0d ns", timeout_ns);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== trdb.f ====
+incdir+source
source/trdb_instr_pkg.sv
source/trdb_packet_pkg.sv
source/trdb_branch_map.sv
source/trdb_packet_emitter.sv
source/trdb_packet_fifo.sv
source/trdb_packet_serializer.sv
source/trdb_trace_top.sv
testbench/trdb_trace_properties.sv
testbench/trdb_trace_tb.sv

// ==== Makefile ====
# Verilator flow for the branch trace encoder
VERILATOR  ?= verilator
FILELIST   ?= trdb.f
TB_TOP     ?= trdb_trace_tb
RTL_TOP    ?= trdb_trace_top
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_MSG   ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

# the run passes only if the pass message shows up as a line of its own
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
